// File: Bender.yml
package:
  name: fc_layer

sources:
  - fc_pkg.sv
  - fc_wb_regs.sv
  - fc_ibuf.sv
  - fc_ctrl.sv
  - fc_cim_tile.sv
  - fc_func_unit.sv
  - fc_layer_top.sv
  - target: test
    files:
      - tb_fc_layer.sv

// File: fc_cim_tile.sv
`default_nettype none

module fc_cim_tile #(
    parameter int INPUT_NEURONS = fc_pkg::INPUT_NEURONS,
    parameter int BUS_WIDTH     = fc_pkg::BUS_WIDTH
) (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire                                         i_w_we,
    input  wire [5:0]                                   i_w_index,  // 4 x input + column
    input  wire fc_pkg::weight_t                        i_w_data,
    input  wire                                         i_we,
    input  wire [ADDR_W-1:0]                            i_addr,
    input  wire [BUS_WIDTH-1:0]                         i_slice,
    input  wire                                         i_start,
    input  wire                                         i_first,
    output logic                                        o_ready,
    output fc_pkg::acc_t [fc_pkg::OUT_NEURONS-1:0]      o_acc
);

    localparam int NUM_ADDR = INPUT_NEURONS / BUS_WIDTH;
    localparam int ADDR_W   = (NUM_ADDR > 1) ? $clog2(NUM_ADDR) : 1;
    localparam int NUM_COL  = fc_pkg::OUT_NEURONS;
    localparam int NUM_W    = INPUT_NEURONS * NUM_COL;
    localparam int COL_W    = (NUM_COL > 1) ? $clog2(NUM_COL) : 1;

    fc_pkg::weight_t            weights [NUM_W];
    logic [INPUT_NEURONS-1:0]   plane;      // Read-data buffer with one bit per input
    logic [COL_W-1:0]           col;
    logic                       first;
    fc_pkg::acc_t               col_sum;
    fc_pkg::acc_t               base;

    always_ff @(posedge clk) begin
        if (i_w_we) begin
            weights[i_w_index] <= i_w_data;
        end
        if (i_we) begin
            plane[i_addr * BUS_WIDTH +: BUS_WIDTH] <= i_slice;
        end
    end

    // Column current from the weights of active rows
    always_comb begin
        col_sum = '0;
        for (int i = 0; i < INPUT_NEURONS; i++) begin
            if (plane[i]) begin
                col_sum = col_sum + fc_pkg::acc_t'(weights[i * NUM_COL + col]);
            end
        end
        base = first ? '0 : (o_acc[col] <<< 1);  // Previous planes weigh twice
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_ready <= 1'b1;
            col     <= '0;
            first   <= 1'b0;
        end else if (o_ready) begin
            if (i_start) begin
                o_ready <= 1'b0;
                col     <= '0;
                first   <= i_first;
            end
        end else begin
            col <= col + 1'b1;
            if (col == COL_W'(NUM_COL - 1)) begin
                o_ready <= 1'b1;  // Last column done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!o_ready) begin
            o_acc[col] <= base + col_sum;
        end
    end

endmodule

`default_nettype wire

// File: fc_ctrl.sv
`default_nettype none

module fc_ctrl #(
    parameter int DATA_SIZE = fc_pkg::DATA_SIZE,
    parameter int NUM_ADDR  = fc_pkg::INPUT_NEURONS / fc_pkg::BUS_WIDTH
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               i_start,
    input  wire               i_cim_ready,
    input  wire               i_func_ready,
    output logic              o_shift_enable,  // Advance input buffer one plane
    output logic              o_busy,
    output logic              o_cim_we,        // Slice write into tile
    output logic              o_cim_start,
    output logic              o_cim_first,     // Plane 0 marker
    output logic [ADDR_W-1:0] o_addr,          // Shared by ibuf and tile
    output logic              o_func_start
);

    localparam int ADDR_W  = (NUM_ADDR > 1) ? $clog2(NUM_ADDR) : 1;
    localparam int PLANE_W = (DATA_SIZE > 1) ? $clog2(DATA_SIZE) : 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CONSUME,
        S_START_CIM,
        S_WAIT_CIM
    } state_t;

    state_t              state;
    state_t              next_state;
    logic [ADDR_W-1:0]   addr;
    logic [ADDR_W-1:0]   next_addr;
    logic [PLANE_W-1:0]  plane;
    logic [PLANE_W-1:0]  next_plane;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            addr  <= '0;
            plane <= '0;
        end else begin
            state <= next_state;
            addr  <= next_addr;
            plane <= next_plane;
        end
    end

    always_comb begin
        next_state     = state;
        next_addr      = addr;
        next_plane     = plane;
        o_busy         = 1'b1;
        o_cim_we       = 1'b0;
        o_cim_start    = 1'b0;
        o_shift_enable = 1'b0;
        o_func_start   = 1'b0;
        case (state)
            S_IDLE: begin
                o_busy     = 1'b0;
                next_addr  = '0;
                next_plane = '0;
                if (i_start && i_cim_ready) begin
                    next_state = S_CONSUME;
                end
            end
            S_CONSUME: begin
                o_cim_we = 1'b1;
                if (addr == ADDR_W'(NUM_ADDR - 1)) begin
                    next_state = S_START_CIM;  // Whole plane moved
                end else begin
                    next_addr = addr + 1'b1;
                end
            end
            S_START_CIM: begin
                next_addr = '0;
                if (i_cim_ready) begin
                    o_cim_start = 1'b1;  // Hold until tile takes it
                end else begin
                    next_state = S_WAIT_CIM;
                end
            end
            S_WAIT_CIM: begin
                if (i_cim_ready) begin
                    if (plane == PLANE_W'(DATA_SIZE - 1)) begin
                        o_func_start = 1'b1;
                        if (i_func_ready) begin
                            next_state = S_IDLE;  // Handoff accepted
                        end
                    end else begin
                        next_plane     = plane + 1'b1;
                        o_shift_enable = 1'b1;
                        next_state     = S_CONSUME;
                    end
                end
            end
            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

    assign o_addr      = addr;
    assign o_cim_first = (state != S_IDLE) && (plane == '0);

endmodule

`default_nettype wire

// File: fc_func_unit.sv
`default_nettype none

module fc_func_unit #(
    parameter int OUT_SHIFT = fc_pkg::OUT_SHIFT
) (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire                                         i_start,
    input  wire fc_pkg::acc_t [fc_pkg::OUT_NEURONS-1:0] i_acc,
    output logic                                        o_ready,
    output fc_pkg::act_t [fc_pkg::OUT_NEURONS-1:0]      o_results,
    output logic                                        o_done
);

    localparam int NUM_COL = fc_pkg::OUT_NEURONS;
    localparam int COL_W   = (NUM_COL > 1) ? $clog2(NUM_COL) : 1;
    localparam int ACT_W   = $bits(fc_pkg::act_t);
    localparam int ACC_W   = fc_pkg::ACC_W;

    fc_pkg::acc_t [NUM_COL-1:0] acc_q;
    logic [COL_W-1:0]           col;
    fc_pkg::acc_t               shifted;
    fc_pkg::act_t               result;

    // ReLU, requantize, saturate
    always_comb begin
        shifted = acc_q[col] >>> OUT_SHIFT;
        if (acc_q[col][ACC_W-1]) begin
            result = '0;
        end else if (|shifted[ACC_W-1:ACT_W]) begin
            result = '1;  // Clamp to 255
        end else begin
            result = shifted[ACT_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready && i_start) begin
            acc_q <= i_acc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_ready   <= 1'b1;
            o_done    <= 1'b0;
            col       <= '0;
            o_results <= '0;
        end else begin
            o_done <= 1'b0;
            if (o_ready) begin
                if (i_start) begin
                    o_ready <= 1'b0;
                    col     <= '0;
                end
            end else begin
                o_results[col] <= result;
                col            <= col + 1'b1;
                if (col == COL_W'(NUM_COL - 1)) begin
                    o_ready <= 1'b1;
                    o_done  <= 1'b1;  // All results written
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: fc_ibuf.sv
`default_nettype none

module fc_ibuf #(
    parameter int INPUT_NEURONS = fc_pkg::INPUT_NEURONS,
    parameter int BUS_WIDTH     = fc_pkg::BUS_WIDTH
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        i_we,
    input  wire [3:0]                  i_index,
    input  wire fc_pkg::act_t          i_wdata,
    input  wire                        i_shift_enable,
    input  wire [ADDR_W-1:0]           i_addr,
    output logic [BUS_WIDTH-1:0]       o_slice
);

    localparam int NUM_ADDR = INPUT_NEURONS / BUS_WIDTH;
    localparam int ADDR_W   = (NUM_ADDR > 1) ? $clog2(NUM_ADDR) : 1;
    localparam int MSB      = fc_pkg::DATA_SIZE - 1;

    fc_pkg::act_t act [INPUT_NEURONS];

    // A shift wins over a host write
    always_ff @(posedge clk) begin
        if (!rst) begin
            if (i_shift_enable) begin
                for (int i = 0; i < INPUT_NEURONS; i++) begin
                    act[i] <= act[i] << 1;  // Next plane moves to the MSB
                end
            end else if (i_we) begin
                act[i_index] <= i_wdata;
            end
        end
    end

    // MSB of each activation in the addressed group
    always_comb begin
        for (int j = 0; j < BUS_WIDTH; j++) begin
            o_slice[j] = act[i_addr * BUS_WIDTH + j][MSB];
        end
    end

endmodule

`default_nettype wire

// File: fc_layer_tests.txt
// Per line: 16 inputs, 64 weights at index 4 x input + column, 4 expected results
// All values are 8-bit hex, weights in two's complement
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 7f 80 11 ee 7f 80 11 ee 7f 80 11 ee 7f 80 11 ee 7f 80 11 ee 7f 80 11 ee 7f 80 11 ee 7f 80 11 ee 7f 80 11 ee 7f 80 11 ee 7f 80 11 ee 7f 80 11 ee 7f 80 11 ee 7f 80 11 ee 7f 80 11 ee 7f 80 11 ee 00 00 00 00
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 7f 80 01 ff 7f 80 01 ff 7f 80 01 ff 7f 80 01 ff 7f 80 01 ff 7f 80 01 ff 7f 80 01 ff 7f 80 01 ff 7f 80 01 ff 7f 80 01 ff 7f 80 01 ff 7f 80 01 ff 7f 80 01 ff 7f 80 01 ff 7f 80 01 ff 7f 80 01 ff ff 00 0f 00
10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 40 02 7f 10 c0 02 7f 10 40 02 7f 10 c0 02 7f 10 40 02 7f 10 c0 02 7f 10 40 02 7f 10 c0 02 7f 10 40 02 01 10 c0 02 01 10 40 02 01 10 c0 02 01 10 40 02 01 10 c0 02 01 10 40 02 01 10 c0 02 01 10 00 02 40
00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff 01 7f fe 20 01 7f fe 20 01 7f fe 20 01 7f fe 20 01 7f fe 20 01 7f fe 20 01 7f fe 20 01 7f fe 20 01 7f fe 20 01 7f fe 20 01 7f fe 20 01 7f fe 20 01 7f fe 20 01 7f fe 20 01 7f fe 20 01 7f fe 20 07 ff 00 ff
ff ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 64 9c 7f 80 64 9c 81 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f c7 00 00 00
01 02 04 08 10 20 40 80 01 02 04 08 10 20 40 80 7f 80 00 40 7f 80 01 40 7f 80 02 40 7f 80 03 40 7f 80 04 40 7f 80 05 40 7f 80 06 40 7f 80 07 40 7f 7f 08 40 7f 7f 09 40 7f 7f 0a 40 7f 7f 0b 40 7f 7f 0c 40 7f 7f 0d 40 7f 7f 0e 40 7f 7f 0f 40 fd 00 13 7f
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 7f 80 20 08 7f 80 20 08 7f 80 20 08 7f 80 20 08 7f 80 20 08 7f 80 20 08 7f 80 20 08 7f 80 20 08 7f 80 20 08 7f 80 20 08 7f 80 20 08 7f 80 20 08 7f 80 20 08 7f 80 20 08 7f 80 20 08 7f 80 20 08 ff 00 ff 40
55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 03 01 ff 10 03 ff 01 00 03 01 ff 10 03 ff 01 00 03 01 ff 10 03 ff 01 00 03 01 ff 10 03 ff 01 00 03 01 ff 10 03 ff 01 00 03 01 ff 10 03 ff 01 00 03 01 ff 10 03 ff 01 00 03 01 ff 10 03 ff 01 00 17 00 02 2a
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 00 00 00 00
00 00 00 00 00 ff 00 00 00 00 00 00 00 00 00 00 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 7f 01 80 02 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 7e 00 00 01

// File: fc_layer_top.sv
`default_nettype none

module fc_layer_top #(
    parameter int INPUT_NEURONS = fc_pkg::INPUT_NEURONS,
    parameter int BUS_WIDTH     = fc_pkg::BUS_WIDTH,
    parameter int OUT_SHIFT     = fc_pkg::OUT_SHIFT
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire fc_pkg::wb_req_t  i_wb,
    output fc_pkg::wb_rsp_t       o_wb
);

    localparam int NUM_ADDR = INPUT_NEURONS / BUS_WIDTH;
    localparam int ADDR_W   = (NUM_ADDR > 1) ? $clog2(NUM_ADDR) : 1;

    logic                                       start;
    logic                                       busy;
    logic                                       act_we;
    logic                                       w_we;
    logic [6:0]                                 wb_index;
    fc_pkg::act_t                               wdata;
    logic                                       shift_enable;
    logic [ADDR_W-1:0]                          addr;
    logic [BUS_WIDTH-1:0]                       slice;
    logic                                       cim_we;
    logic                                       cim_start;
    logic                                       cim_first;
    logic                                       cim_ready;
    logic                                       func_start;
    logic                                       func_ready;
    logic                                       done;
    fc_pkg::acc_t [fc_pkg::OUT_NEURONS-1:0]     acc;
    fc_pkg::act_t [fc_pkg::OUT_NEURONS-1:0]     results;

    fc_wb_regs wb_regs_i (
        .clk       (clk),
        .rst       (rst),
        .i_wb      (i_wb),
        .o_wb      (o_wb),
        .i_busy    (busy),
        .i_done    (done),
        .i_results (results),
        .o_start   (start),
        .o_act_we  (act_we),
        .o_w_we    (w_we),
        .o_index   (wb_index),
        .o_wdata   (wdata)
    );

    fc_ibuf #(
        .INPUT_NEURONS (INPUT_NEURONS),
        .BUS_WIDTH     (BUS_WIDTH)
    ) ibuf_i (
        .clk            (clk),
        .rst            (rst),
        .i_we           (act_we),
        .i_index        (wb_index[3:0]),
        .i_wdata        (wdata),
        .i_shift_enable (shift_enable),
        .i_addr         (addr),
        .o_slice        (slice)
    );

    fc_ctrl #(
        .DATA_SIZE (fc_pkg::DATA_SIZE),
        .NUM_ADDR  (NUM_ADDR)
    ) ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .i_start        (start),
        .i_cim_ready    (cim_ready),
        .i_func_ready   (func_ready),
        .o_shift_enable (shift_enable),
        .o_busy         (busy),
        .o_cim_we       (cim_we),
        .o_cim_start    (cim_start),
        .o_cim_first    (cim_first),
        .o_addr         (addr),
        .o_func_start   (func_start)
    );

    fc_cim_tile #(
        .INPUT_NEURONS (INPUT_NEURONS),
        .BUS_WIDTH     (BUS_WIDTH)
    ) cim_tile_i (
        .clk       (clk),
        .rst       (rst),
        .i_w_we    (w_we),
        .i_w_index (wb_index[5:0]),
        .i_w_data  (fc_pkg::weight_t'(wdata)),
        .i_we      (cim_we),
        .i_addr    (addr),
        .i_slice   (slice),
        .i_start   (cim_start),
        .i_first   (cim_first),
        .o_ready   (cim_ready),
        .o_acc     (acc)
    );

    fc_func_unit #(
        .OUT_SHIFT (OUT_SHIFT)
    ) func_unit_i (
        .clk       (clk),
        .rst       (rst),
        .i_start   (func_start),
        .i_acc     (acc),
        .o_ready   (func_ready),
        .o_results (results),
        .o_done    (done)
    );

endmodule

`default_nettype wire

// File: fc_pkg.sv
`default_nettype none

package fc_pkg;

    localparam int DATA_SIZE     = 8;   // Activation bits and plane count
    localparam int INPUT_NEURONS = 16;
    localparam int OUT_NEURONS   = 4;   // Crossbar columns
    localparam int BUS_WIDTH     = 4;   // Plane bits per address
    localparam int OUT_SHIFT     = 8;   // Requantization shift
    localparam int ACC_W         = 21;  // Holds 16 x 128 x 255 with sign

    typedef logic        [DATA_SIZE-1:0] act_t;
    typedef logic signed [7:0]           weight_t;
    typedef logic signed [ACC_W-1:0]     acc_t;

    typedef logic [6:0]  wb_adr_t;  // Word address
    typedef logic [31:0] wb_data_t;

    // Host to slave
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_adr_t  adr;
        wb_data_t dat;
    } wb_req_t;

    // Slave to host
    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: fc_wb_regs.sv
`default_nettype none

module fc_wb_regs (
    input  wire                                           clk,
    input  wire                                           rst,
    input  wire fc_pkg::wb_req_t                          i_wb,
    output fc_pkg::wb_rsp_t                               o_wb,
    input  wire                                           i_busy,
    input  wire                                           i_done,
    input  wire fc_pkg::act_t [fc_pkg::OUT_NEURONS-1:0]   i_results,
    output logic                                          o_start,   // One-cycle start pulse
    output logic                                          o_act_we,
    output logic                                          o_w_we,
    output logic [6:0]                                    o_index,   // Offset inside region
    output fc_pkg::act_t                                  o_wdata
);

    localparam fc_pkg::wb_adr_t W_BASE = 7'd32;
    localparam int RES_SEL_W = $clog2(fc_pkg::OUT_NEURONS);

    logic            ack_q;
    logic            done_q;
    logic            req;
    logic            wr;
    logic            region_ctrl;
    logic            region_act;
    logic            region_w;
    logic            region_res;
    fc_pkg::wb_data_t rdata;
    fc_pkg::wb_data_t rdata_q;

    assign req = i_wb.cyc && i_wb.stb && !ack_q;  // No new request during ack
    assign wr  = req && i_wb.we;

    assign region_ctrl = (i_wb.adr == '0);
    assign region_act  = (i_wb.adr[6:5] == 2'd0) && i_wb.adr[4];     // 16 to 31
    assign region_w    = (i_wb.adr[6:5] == 2'd1) || (i_wb.adr[6:5] == 2'd2);
    assign region_res  = (i_wb.adr[6:5] == 2'd3) && (i_wb.adr[4:0] < fc_pkg::OUT_NEURONS);

    always_comb begin
        rdata = '0;
        if (region_ctrl) begin
            rdata[0] = i_busy;
            rdata[1] = done_q;
        end else if (region_res) begin
            rdata[fc_pkg::DATA_SIZE-1:0] = i_results[i_wb.adr[RES_SEL_W-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q    <= 1'b0;
            o_start  <= 1'b0;
            o_act_we <= 1'b0;
            o_w_we   <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            ack_q    <= req;
            o_start  <= wr && region_ctrl && i_wb.dat[0] && !i_busy;  // Start ignored while busy
            o_act_we <= wr && region_act && !i_busy;
            o_w_we   <= wr && region_w && !i_busy;
            if (o_start) begin
                done_q <= 1'b0;  // New run clears done
            end else if (i_done) begin
                done_q <= 1'b1;
            end
        end
    end

    // Bus payload captured with each request
    always_ff @(posedge clk) begin
        if (req) begin
            rdata_q <= i_wb.we ? '0 : rdata;
            o_index <= region_w ? i_wb.adr - W_BASE : i_wb.adr;
            o_wdata <= i_wb.dat[fc_pkg::DATA_SIZE-1:0];
        end
    end

    assign o_wb = fc_pkg::wb_rsp_t'{ack: ack_q, dat: rdata_q};

endmodule

`default_nettype wire

// File: tb_fc_layer.sv
`default_nettype none

module tb_fc_layer;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS   = 10;
    localparam int NUM_IN      = fc_pkg::INPUT_NEURONS;
    localparam int NUM_OUT     = fc_pkg::OUT_NEURONS;
    localparam int NUM_W       = NUM_IN * NUM_OUT;
    localparam int VEC_LEN     = NUM_IN + NUM_W + NUM_OUT;  // Bytes per test line
    localparam int DRIVE_DLY   = 2;
    localparam int ACK_TIMEOUT = 8;
    localparam int DONE_POLLS  = 200;

    localparam logic [6:0] ADR_CTRL = 7'd0;
    localparam logic [6:0] ADR_ACT  = 7'd16;
    localparam logic [6:0] ADR_W    = 7'd32;
    localparam logic [6:0] ADR_RES  = 7'd96;

    logic            clk;
    logic            rst;
    fc_pkg::wb_req_t wb_req;
    fc_pkg::wb_rsp_t wb_rsp;
    logic [7:0]      vec_mem [0:NUM_TESTS*VEC_LEN-1];
    logic [31:0]     lfsr_q;
    int              errors;

    fc_layer_top #(
        .INPUT_NEURONS (fc_pkg::INPUT_NEURONS),
        .BUS_WIDTH     (fc_pkg::BUS_WIDTH),
        .OUT_SHIFT     (fc_pkg::OUT_SHIFT)
    ) dut_i (
        .clk  (clk),
        .rst  (rst),
        .i_wb (wb_req),
        .o_wb (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);  // One step per bit
            val    = (val << 1) | int'(lfsr_q[0]);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
        end
        #DRIVE_DLY;
    endtask

    // One classic cycle followed by a random idle gap
    task automatic bus_access(input logic we, input logic [6:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int   cycles;
        int   gap;
        logic got_ack;
        cycles     = 0;
        got_ack    = 1'b0;
        rdat       = '0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        while (!got_ack && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
            got_ack = wb_rsp.ack;
        end
        if (!got_ack) begin
            $display("Missing acknowledge for address 0x%h", adr);
            errors++;
        end else begin
            check("ack_latency", cycles, 1);
            rdat = wb_rsp.dat;
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        idle_cycles(1);
        check("ack_after", wb_rsp.ack, 0);  // Single-cycle ack
        rand_bits(2, gap);
        if (gap > 0) begin
            idle_cycles(gap);
        end
    endtask

    task automatic wb_write(input logic [6:0] adr, input logic [31:0] wdat);
        logic [31:0] rd_dummy;
        bus_access(1'b1, adr, wdat, rd_dummy);
    endtask

    task automatic wb_read(input logic [6:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, adr, 32'h0, rdat);
    endtask

    task automatic run_vector(input int t);
        int          base;
        int          off;
        int          stride;
        int          idx;
        int          polls;
        logic [31:0] rdat;
        base = t * VEC_LEN;
        for (int i = 0; i < NUM_IN; i++) begin
            wb_write(ADR_ACT + 7'(i), 32'(vec_mem[base + i]));
        end
        rand_bits(6, off);
        rand_bits(5, stride);
        stride = 2 * stride + 1;  // Odd stride covers all 64 slots
        for (int k = 0; k < NUM_W; k++) begin
            idx = (off + k * stride) % NUM_W;
            wb_write(ADR_W + 7'(idx), 32'(vec_mem[base + NUM_IN + idx]));
        end
        wb_write(ADR_CTRL, 32'h1);
        wb_read(ADR_CTRL, rdat);
        check("status_running", rdat, 32'h1);           // Busy and done cleared
        wb_write(ADR_CTRL, 32'h1);                      // Second start
        wb_write(ADR_W, 32'(~vec_mem[base + NUM_IN]));  // Weight write mid-run
        polls = 0;
        rdat  = '0;
        while (!rdat[1] && polls < DONE_POLLS) begin
            wb_read(ADR_CTRL, rdat);
            polls++;
        end
        if (!rdat[1]) begin
            $display("Timeout waiting for the done bit on vector %0d", t);
            errors++;
        end else begin
            check("status_done", rdat, 32'h2);
        end
        for (int j = 0; j < NUM_OUT; j++) begin
            wb_read(ADR_RES + 7'(j), rdat);
            check($sformatf("result[%0d]", j), rdat,
                  32'(vec_mem[base + NUM_IN + NUM_W + j]));
        end
    endtask

    initial begin
        logic [31:0] rdat;
        errors = 0;
        lfsr_q = 32'ha6e7;
        rst    = 1'b1;
        wb_req = '0;
        $readmemh("fc_layer_tests.txt", vec_mem);
        if ($isunknown(vec_mem[NUM_TESTS*VEC_LEN-1])) begin
            $display("Test data file is missing or shorter than expected");
            errors++;
        end
        repeat (4) begin
            @(posedge clk);
        end
        #DRIVE_DLY;
        rst = 1'b0;
        idle_cycles(1);
        wb_read(ADR_CTRL, rdat);
        check("status_after_reset", rdat, 32'h0);
        for (int j = 0; j < NUM_OUT; j++) begin
            wb_read(ADR_RES + 7'(j), rdat);
            check("result_after_reset", rdat, 32'h0);
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_vector(t);
        end
        $display("Error count: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
fc_pkg.sv
fc_wb_regs.sv
fc_ibuf.sv
fc_ctrl.sv
fc_cim_tile.sv
fc_func_unit.sv
fc_layer_top.sv
tb_fc_layer.sv
